//--- Bender.yml
package:
  name: matrix_display

sources:
  - include_dirs:
      - src
    files:
      - src/display_pkg.sv
      - src/digit_glyph.sv
      - src/raster_timebase.sv
      - src/vector_panel.sv
      - src/matrix_panel.sv
      - src/bar_chart.sv
      - src/pixel_compositor.sv
      - src/matrix_display.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/matrix_display_tb.sv

//--- bench/matrix_display_tb.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module matrix_display_tb
    import display_pkg::*;
;

    localparam int BLINK_BIT = 3;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN = 3;
    localparam int NUM_TESTS = 9;
    localparam int BLANK_LEN = 200;
    localparam int MAT_W = 192;
    localparam int MAT_H = 176;
    localparam int VEC_SW = 108;
    localparam int VEC_SH = 188;
    localparam int CHART_W = 464;
    localparam int CHART_H = 194;
    localparam int VCELL_W = 104;
    localparam int VCELL_H = 49;
    localparam int MCELL_W = 46;
    localparam int MCELL_H = 46;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + BLANK_LEN + MAT_W * MAT_H
        + VEC_SW * VEC_SH + CHART_W * CHART_H + 3 * VCELL_W * VCELL_H
        + 3 * MCELL_W * MCELL_H + NUM_TESTS * DRAIN + 100;

    // layout figures derived from the display geometry
    localparam int VEC_W = `VEC_X1 - `VEC_X0;
    localparam int VEC_H = 4 * `VEC_CELL_H;
    localparam int VEC_ONES = `VEC_DIGIT_X + (`FONT_W << `VEC_DIGIT_SCALE) + `VEC_DIGIT_GAP;
    localparam int MAT_GRID = 4 * `MAT_CELL;
    localparam int MAT_ONES = `MAT_DIGIT_X + (`FONT_W << `MAT_DIGIT_SCALE) + `MAT_DIGIT_GAP;
    localparam int BW = `MAT_BRACKET_W;
    localparam int CW = `CHART_X1 - `CHART_X0;
    localparam int CH = `CHART_Y1 - `CHART_Y0;
    localparam int HALF = CW / 2;
    localparam int BOTTOM = CH - `BAR_BASE_GAP;
    localparam int PITCH = `BAR_WIDTH + `BAR_SPACING;

    logic        clk;
    logic        rst;
    raster_t     raster;
    frame_data_t data;
    edit_t       edit;
    rgb_t        rgb;

    rgb_t  exp_q[$];
    string name_q[$];
    string test_name;
    int    seen [0:4095];
    int    model_cnt = 0;
    int    cycles = 0;
    int    mismatches = 0;
    int    failures = 0;

    matrix_display #(.BLINK_BIT(BLINK_BIT)) DUT (
        .clk    (clk),
        .rst    (rst),
        .raster (raster),
        .data   (data),
        .edit   (edit),
        .rgb    (rgb)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int wrap10(int v);
        return v & 1023;
    endfunction

    // 5x7 decimal font with the top row first and the leftmost column in the high bit of a row
    function automatic logic [34:0] font_bits(int d);
        case (d)
            0: return 35'b01110_10001_10011_10101_11001_10001_01110;
            1: return 35'b00100_01100_00100_00100_00100_00100_01110;
            2: return 35'b01110_10001_00001_00110_01000_10000_11111;
            3: return 35'b11110_00001_00001_01110_00001_00001_11110;
            4: return 35'b00010_00110_01010_10010_11111_00010_00010;
            5: return 35'b11111_10000_11110_00001_00001_10001_01110;
            6: return 35'b01110_10000_11110_10001_10001_10001_01110;
            7: return 35'b11111_00001_00010_00100_01000_10000_10000;
            8: return 35'b01110_10001_10001_01110_10001_10001_01110;
            9: return 35'b01110_10001_10001_01111_00001_00001_01110;
            default: return '0;
        endcase
    endfunction

    function automatic logic glyph_on(int digit, int gx, int gy, int scale);
        logic [34:0] bits;
        if ((digit > 9) || (gx >= (`FONT_W << scale)) || (gy >= (`FONT_H << scale)))
            return 1'b0;
        bits = font_bits(digit);
        return bits[34 - 5 * (gy >> scale) - (gx >> scale)];
    endfunction

    function automatic rgb_t expected_colour(raster_t r, frame_data_t d, edit_t e, logic blink);
        int   x;
        int   y;
        int   lx;
        int   ly;
        int   cx;
        int   cy;
        int   idx;
        int   col;
        int   value;
        int   shown;
        int   gx;
        int   height;
        logic caps;
        logic v_in, v_br, v_dig, v_fill, v_bord;
        logic m_rows, m_grid, m_br, m_cell, m_dig, m_fill, m_bord;
        logic c_in, right, c_bar, c_frame;
        x = wrap10(r.hcount - `H_BACK);
        y = wrap10(r.vcount - `V_BACK);

        // vector column
        lx = wrap10(x - `VEC_X0);
        ly = wrap10(y - `VEC_Y0);
        v_in = (lx < VEC_W) && (ly < VEC_H);
        idx = (ly / `VEC_CELL_H) % 4;
        cy = ly - idx * `VEC_CELL_H;
        value = d.vec[idx];
        shown = (lx >= VEC_ONES) ? value % 10 : value / 10;
        gx = (lx >= VEC_ONES) ? wrap10(lx - VEC_ONES) : wrap10(lx - `VEC_DIGIT_X);
        v_dig = v_in && glyph_on(shown, gx, wrap10(cy - `VEC_DIGIT_Y), `VEC_DIGIT_SCALE);
        caps = (ly < `BRACKET_CAP) || (ly >= VEC_H - `BRACKET_CAP);
        v_br = v_in && (((lx < `VEC_BRACKET_W) && (caps || (lx < `BRACKET_SPINE)))
            || ((lx >= VEC_W - `VEC_BRACKET_W) && (caps || (lx >= VEC_W - `BRACKET_SPINE))));
        v_fill = v_in && e.edit_mode && e.vec_target && (idx == e.row);
        v_bord = v_fill && ((cy < `CURSOR_BAND) || (cy >= `VEC_CELL_H - `CURSOR_BAND)
            || (lx < `VEC_CURSOR_INSET) || (lx >= VEC_W - `VEC_CURSOR_INSET));

        // matrix grid
        lx = wrap10(x - `MAT_X0);
        ly = wrap10(y - `MAT_Y0);
        m_rows = (ly >= `MAT_GRID_Y) && (ly < `MAT_GRID_Y + MAT_GRID);
        m_grid = m_rows && (lx >= BW) && (lx < BW + MAT_GRID);
        idx = (wrap10(ly - `MAT_GRID_Y) / `MAT_CELL) % 4;
        col = (wrap10(lx - BW) / `MAT_CELL) % 4;
        cx = wrap10(lx - BW) - col * `MAT_CELL;
        cy = wrap10(ly - `MAT_GRID_Y) - idx * `MAT_CELL;
        value = d.mat[idx][col];
        shown = (cx >= MAT_ONES) ? value % 10 : value / 10;
        gx = (cx >= MAT_ONES) ? wrap10(cx - MAT_ONES) : wrap10(cx - `MAT_DIGIT_X);
        m_dig = m_grid && glyph_on(shown, gx, wrap10(cy - `MAT_DIGIT_Y), `MAT_DIGIT_SCALE);
        m_cell = m_grid && ((cx < 1) || (cx >= `MAT_CELL - 1) || (cy < 1) || (cy >= `MAT_CELL - 1));
        caps = (ly < `MAT_GRID_Y + `BRACKET_CAP) || (ly >= `MAT_GRID_Y + MAT_GRID - `BRACKET_CAP);
        m_br = m_rows && (((lx < BW) && (caps || (lx < `BRACKET_SPINE)))
            || ((lx >= BW + MAT_GRID) && (lx < 2 * BW + MAT_GRID)
            && (caps || (lx >= 2 * BW + MAT_GRID - `BRACKET_SPINE))));
        m_fill = m_grid && e.edit_mode && !e.vec_target && (idx == e.row) && (col == e.col);
        m_bord = m_fill && ((cx < `CURSOR_BAND) || (cx >= `MAT_CELL - `CURSOR_BAND)
            || (cy < `CURSOR_BAND) || (cy >= `MAT_CELL - `CURSOR_BAND));

        // each bar chart half is measured from its own left edge
        lx = wrap10(x - `CHART_X0);
        ly = wrap10(y - `CHART_Y0);
        c_in = (lx < CW) && (ly < CH);
        right = (lx >= HALF);
        cx = right ? lx - HALF : lx;
        gx = wrap10(cx - `BAR_X_START);
        idx = gx / PITCH;
        value = right ? d.v_new[idx % 4] : d.v_old[idx % 4];
        height = value * `BAR_SCALE;
        if (height > `BAR_MAX)
            height = `BAR_MAX;
        c_bar = c_in && (cx >= `BAR_X_START) && (idx < 4) && (gx - idx * PITCH < `BAR_WIDTH)
            && (ly >= BOTTOM - height) && (ly < BOTTOM);
        c_frame = c_in && ((lx < `CHART_LINE) || (lx >= CW - `CHART_LINE) || (ly < `CHART_LINE)
            || (ly >= CH - `CHART_LINE)
            || ((lx >= HALF - `CHART_LINE / 2) && (lx < HALF + `CHART_LINE / 2))
            || ((ly >= BOTTOM) && (ly < BOTTOM + `CHART_LINE)));

        if (!r.bright)
            return `BLACK;
        if ((v_fill || m_fill) && e.locked)
            return `GREEN;
        if ((v_fill || m_fill) && blink)
            return `YELLOW;
        if (v_bord || m_bord)
            return e.locked ? `GREEN : `ORANGE;
        if (c_bar)
            return right ? `GREEN : `CYAN;
        if (c_frame)
            return `GRAY;
        if (v_br || m_br)
            return `WHITE;
        if (m_cell)
            return `GRAY;
        if (v_dig)
            return `CYAN;
        if (m_dig)
            return `WHITE;
        return `BLACK;
    endfunction

    task automatic check_rgb(string name, rgb_t want, rgb_t got);
        if (got !== want)
        begin
            mismatches++;
            $display("mismatch in %s at %0t: expected %h, actual %h", name, $time, want, got);
        end
    endtask

    // expected colours wait two cycles to line up with the DUT pipeline
    always @(posedge clk)
    begin : compare
        rgb_t want;
        if (rst)
        begin
            model_cnt = 0;
            exp_q.delete();
            name_q.delete();
            repeat (2)
            begin
                exp_q.push_back(`BLACK);
                name_q.push_back("reset");
            end
        end
        else
        begin
            want = expected_colour(raster, data, edit, model_cnt[BLINK_BIT]);
            model_cnt = model_cnt + 1;
            exp_q.push_back(want);
            name_q.push_back(test_name);
            if (exp_q.size() > 2)
            begin
                check_rgb(name_q.pop_front(), exp_q.pop_front(), rgb);
                if (!$isunknown(rgb))
                    seen[rgb] = seen[rgb] + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic drive_pixel(int x, int y, logic bright);
        raster.hcount = 10'(x + `H_BACK);
        raster.vcount = 10'(y + `V_BACK);
        raster.bright = bright;
        @(negedge clk);
    endtask

    task automatic sweep(int x0, int y0, int w, int h);
        for (int y = y0; y < y0 + h; y++)
            for (int x = x0; x < x0 + w; x++)
                drive_pixel(x, y, 1'b1);
    endtask

    task automatic randomize_data();
        for (int r = 0; r < 4; r++)
        begin
            data.vec[r] = 4'($urandom);
            data.v_old[r] = 4'($urandom);
            data.v_new[r] = 4'($urandom);
            for (int c = 0; c < 4; c++)
                data.mat[r][c] = 4'($urandom);
        end
    endtask

    task automatic set_edit(logic mode, logic target, logic lock, logic [1:0] row,
                            logic [1:0] col);
        edit.edit_mode = mode;
        edit.vec_target = target;
        edit.locked = lock;
        edit.row = row;
        edit.col = col;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        for (int i = 0; i < 4096; i++)
            seen[i] = 0;
    endtask

    // blank until the last swept pixel has been compared
    task automatic end_test();
        raster.bright = 1'b0;
        repeat (DRAIN) @(negedge clk);
    endtask

    task automatic require_colour(rgb_t c, string what);
        if (seen[c] == 0)
        begin
            failures++;
            $display("%s: no %s pixel was produced", test_name, what);
        end
    endtask

    task automatic forbid_colour(rgb_t c, string what);
        if (seen[c] != 0)
        begin
            failures++;
            $display("%s: %0d %s pixels appeared where none belong", test_name, seen[c], what);
        end
    endtask

    initial
    begin
        void'($urandom(32'haeaa12b7));
        rst = 1'b1;
        raster = '0;
        data = '0;
        edit = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("blanking");
        randomize_data();
        set_edit(1'b1, 1'b0, 1'b1, 2'd0, 2'd0);
        repeat (BLANK_LEN)
            drive_pixel($urandom_range(639), $urandom_range(479), 1'b0);
        end_test();
        forbid_colour(`GREEN, "green");

        begin_test("matrix");
        randomize_data();
        data.mat[2][1] = 4'd15;
        set_edit(1'b0, 1'b0, 1'b0, 2'd0, 2'd0);
        sweep(8, 266, MAT_W, MAT_H);
        end_test();
        require_colour(`WHITE, "white");
        require_colour(`GRAY, "gray");

        begin_test("vector");
        randomize_data();
        data.vec[1] = 4'd12;
        data.vec[3] = 4'd15;
        sweep(16, 26, VEC_SW, VEC_SH);
        end_test();
        require_colour(`CYAN, "cyan");
        require_colour(`WHITE, "white");

        begin_test("bar chart");
        data.v_old = {4'd12, 4'd15, 4'd5, 4'd0};
        data.v_new = {4'd9, 4'd5, 4'd0, 4'd15};
        sweep(158, 28, CHART_W, CHART_H);
        end_test();
        require_colour(`CYAN, "cyan");
        require_colour(`GREEN, "green");
        require_colour(`GRAY, "gray");

        begin_test("vector cursor");
        randomize_data();
        set_edit(1'b1, 1'b1, 1'b0, 2'd2, 2'd0);
        sweep(18, 118, VCELL_W, VCELL_H);
        end_test();
        require_colour(`YELLOW, "yellow");
        require_colour(`ORANGE, "orange");

        begin_test("vector cursor locked");
        set_edit(1'b1, 1'b1, 1'b1, 2'd2, 2'd0);
        sweep(18, 118, VCELL_W, VCELL_H);
        end_test();
        require_colour(`GREEN, "green");
        forbid_colour(`YELLOW, "yellow");

        begin_test("matrix cursor");
        set_edit(1'b1, 1'b0, 1'b0, 2'd1, 2'd3);
        sweep(144, 310, MCELL_W, MCELL_H);
        end_test();
        require_colour(`YELLOW, "yellow");
        require_colour(`ORANGE, "orange");

        begin_test("matrix cursor locked");
        set_edit(1'b1, 1'b0, 1'b1, 2'd1, 2'd3);
        sweep(144, 310, MCELL_W, MCELL_H);
        end_test();
        require_colour(`GREEN, "green");
        forbid_colour(`ORANGE, "orange");

        begin_test("no edit mode");
        set_edit(1'b0, 1'b1, 1'b0, 2'd2, 2'd0);
        sweep(18, 118, VCELL_W, VCELL_H);
        set_edit(1'b0, 1'b0, 1'b0, 2'd1, 2'd3);
        sweep(144, 310, MCELL_W, MCELL_H);
        end_test();
        forbid_colour(`YELLOW, "yellow");
        forbid_colour(`ORANGE, "orange");
        forbid_colour(`GREEN, "green");

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches == 0) && (failures == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- matrix_display.f
+incdir+src
src/display_pkg.sv
src/digit_glyph.sv
src/raster_timebase.sv
src/vector_panel.sv
src/matrix_panel.sv
src/bar_chart.sv
src/pixel_compositor.sv
src/matrix_display.sv
bench/matrix_display_tb.sv

//--- src/bar_chart.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module bar_chart
    import display_pkg::*;
(
    input  pixel_t       pixel,
    input  vec4_t        v_old,
    input  vec4_t        v_new,
    output chart_flags_t flags
);

    localparam int CW = `CHART_X1 - `CHART_X0;
    localparam int CH = `CHART_Y1 - `CHART_Y0;
    localparam int HALF = CW / 2;
    localparam int BOTTOM = CH - `BAR_BASE_GAP;
    localparam int PITCH = `BAR_WIDTH + `BAR_SPACING;
    localparam int LINE = `CHART_LINE;

    logic [9:0] lx;
    logic [9:0] ly;
    logic [9:0] hx;
    logic [9:0] off;
    logic [9:0] slot;
    logic [9:0] bar_x;
    logic [9:0] scaled;
    logic [9:0] height;
    logic       in_chart;
    logic       right;
    logic       in_bar;
    digit_t     value;

    assign lx = pixel.x - 10'(`CHART_X0);
    assign ly = pixel.y - 10'(`CHART_Y0);
    assign in_chart = (lx < CW) && (ly < CH);

    // both halves share one bar layout, measured from their own left edge
    assign right = (lx >= HALF);
    assign hx = right ? lx - 10'(HALF) : lx;
    assign off = hx - 10'(`BAR_X_START);
    assign slot = off / 10'(PITCH);
    assign bar_x = off - 10'(slot * PITCH);

    assign value = right ? v_new[slot[1:0]] : v_old[slot[1:0]];
    assign scaled = 10'(value) * 10'(`BAR_SCALE);
    assign height = (scaled > 10'(`BAR_MAX)) ? 10'(`BAR_MAX) : scaled;
    assign in_bar = in_chart && (hx >= `BAR_X_START) && (slot < 4) && (bar_x < `BAR_WIDTH)
        && (ly >= 10'(BOTTOM) - height) && (ly < BOTTOM);

    assign flags.old_bar = in_bar && !right;
    assign flags.new_bar = in_bar && right;
    // border, centre divider and baseline
    assign flags.frame = in_chart
        && ((lx < LINE) || (lx >= CW - LINE) || (ly < LINE) || (ly >= CH - LINE)
        || ((lx >= HALF - LINE / 2) && (lx < HALF + LINE / 2))
        || ((ly >= BOTTOM) && (ly < BOTTOM + LINE)));

endmodule

//--- src/digit_glyph.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module digit_glyph
    import display_pkg::*;
#(
    parameter int SCALE = 0
)
(
    input  digit_t     digit,
    input  logic [9:0] x,
    input  logic [9:0] y,
    output logic       pixel
);

    localparam int GLYPH_W = `FONT_W << SCALE;
    localparam int GLYPH_H = `FONT_H << SCALE;

    // 7 rows of 5 bits with the top row in the high bits and the leftmost column as msb
    function automatic logic [34:0] glyph_bits(input digit_t d);
        logic [34:0] bits;
        case (d)
            4'd0: bits = 35'b01110_10001_10011_10101_11001_10001_01110;
            4'd1: bits = 35'b00100_01100_00100_00100_00100_00100_01110;
            4'd2: bits = 35'b01110_10001_00001_00110_01000_10000_11111;
            4'd3: bits = 35'b11110_00001_00001_01110_00001_00001_11110;
            4'd4: bits = 35'b00010_00110_01010_10010_11111_00010_00010;
            4'd5: bits = 35'b11111_10000_11110_00001_00001_10001_01110;
            4'd6: bits = 35'b01110_10000_11110_10001_10001_10001_01110;
            4'd7: bits = 35'b11111_00001_00010_00100_01000_10000_10000;
            4'd8: bits = 35'b01110_10001_10001_01110_10001_10001_01110;
            4'd9: bits = 35'b01110_10001_10001_01111_00001_00001_01110;
            // blank above 9
            default: bits = '0;
        endcase
        return bits;
    endfunction

    logic [34:0] glyph;
    logic [2:0]  gx;
    logic [2:0]  gy;

    assign glyph = glyph_bits(digit);
    assign gx = 3'(x >> SCALE);
    assign gy = 3'(y >> SCALE);

    always_comb
    begin
        pixel = 1'b0;
        if ((x < GLYPH_W) && (y < GLYPH_H))
        begin
            pixel = glyph[34 - 5 * gy - gx];
        end
    end

endmodule

//--- src/display_pkg.sv
package display_pkg;

    typedef logic [3:0] digit_t;

    // element i in bits 4i up
    typedef digit_t [3:0] vec4_t;

    // row r in bits 16r up
    typedef vec4_t [3:0] mat4_t;

    typedef logic [11:0] rgb_t;

    typedef struct packed {
        logic [9:0] hcount;
        logic [9:0] vcount;
        logic       bright;
    } raster_t;

    typedef struct packed {
        logic       bright;
        logic [9:0] x;
        logic [9:0] y;
    } pixel_t;

    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
        logic       locked;
        logic       edit_mode;
        logic       vec_target;
    } edit_t;

    typedef struct packed {
        mat4_t mat;
        vec4_t vec;
        vec4_t v_old;
        vec4_t v_new;
    } frame_data_t;

    typedef struct packed {
        logic bracket;
        logic digit;
        logic cursor_fill;
        logic cursor_border;
    } vec_flags_t;

    typedef struct packed {
        logic bracket;
        logic cell_border;
        logic digit;
        logic cursor_fill;
        logic cursor_border;
    } mat_flags_t;

    typedef struct packed {
        logic old_bar;
        logic new_bar;
        logic frame;
    } chart_flags_t;

endpackage

//--- src/display_settings.svh
`ifndef DISPLAY_SETTINGS_SVH
`define DISPLAY_SETTINGS_SVH

// counter offsets to visible pixel 0
`define H_BACK 144
`define V_BACK 35

`define FONT_W 5
`define FONT_H 7

// input vector column
`define VEC_X0 20
`define VEC_X1 120
`define VEC_Y0 30
`define VEC_CELL_H 45
`define VEC_BRACKET_W 8
`define VEC_CURSOR_INSET 13
`define VEC_DIGIT_SCALE 1
`define VEC_DIGIT_X 18
`define VEC_DIGIT_Y 10
`define VEC_DIGIT_GAP 3

// matrix grid sits MAT_GRID_Y below the origin
`define MAT_X0 10
`define MAT_Y0 250
`define MAT_CELL 42
`define MAT_BRACKET_W 10
`define MAT_GRID_Y 20
`define MAT_DIGIT_SCALE 0
`define MAT_DIGIT_X 4
`define MAT_DIGIT_Y 10
`define MAT_DIGIT_GAP 1

// bracket caps and spine and the cursor border band
`define BRACKET_CAP 4
`define BRACKET_SPINE 3
`define CURSOR_BAND 5

// bar chart
`define CHART_X0 160
`define CHART_X1 620
`define CHART_Y0 30
`define CHART_Y1 220
`define CHART_LINE 2
`define BAR_X_START 25
`define BAR_BASE_GAP 15
`define BAR_WIDTH 45
`define BAR_SPACING 10
`define BAR_SCALE 10
`define BAR_MAX 160

`define BLACK 12'h000
`define WHITE 12'hFFF
`define YELLOW 12'hFF0
`define CYAN 12'h0FF
`define GREEN 12'h0F0
`define GRAY 12'h444
`define ORANGE 12'hF80

`endif

//--- src/matrix_display.sv
`timescale 1ns/1ns

module matrix_display
    import display_pkg::*;
#(
    parameter int BLINK_BIT = 24
)
(
    input  logic        clk,
    input  logic        rst,
    input  raster_t     raster,
    input  frame_data_t data,
    input  edit_t       edit,
    output rgb_t        rgb
);

    pixel_t       pixel;
    frame_data_t  data_q;
    edit_t        edit_q;
    logic         blink;
    vec_flags_t   vflags;
    mat_flags_t   mflags;
    chart_flags_t cflags;

    raster_timebase #(.BLINK_BIT(BLINK_BIT)) u_timebase (
        .clk    (clk),
        .rst    (rst),
        .raster (raster),
        .data   (data),
        .edit   (edit),
        .pixel  (pixel),
        .data_q (data_q),
        .edit_q (edit_q),
        .blink  (blink)
    );

    vector_panel u_vector (
        .pixel (pixel),
        .vec   (data_q.vec),
        .edit  (edit_q),
        .flags (vflags)
    );

    matrix_panel u_matrix (
        .pixel (pixel),
        .mat   (data_q.mat),
        .edit  (edit_q),
        .flags (mflags)
    );

    bar_chart u_chart (
        .pixel (pixel),
        .v_old (data_q.v_old),
        .v_new (data_q.v_new),
        .flags (cflags)
    );

    pixel_compositor u_compositor (
        .clk    (clk),
        .rst    (rst),
        .bright (pixel.bright),
        .vflags (vflags),
        .mflags (mflags),
        .cflags (cflags),
        .locked (edit_q.locked),
        .blink  (blink),
        .rgb    (rgb)
    );

endmodule

//--- src/matrix_panel.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module matrix_panel
    import display_pkg::*;
(
    input  pixel_t     pixel,
    input  mat4_t      mat,
    input  edit_t      edit,
    output mat_flags_t flags
);

    localparam int GRID = 4 * `MAT_CELL;
    localparam int BW = `MAT_BRACKET_W;
    localparam int GY = `MAT_GRID_Y;
    localparam int DIGIT_W = `FONT_W << `MAT_DIGIT_SCALE;
    localparam int ONES_X = `MAT_DIGIT_X + DIGIT_W + `MAT_DIGIT_GAP;

    logic [9:0] lx;
    logic [9:0] ly;
    logic [9:0] gx;
    logic [9:0] gy;
    logic [9:0] cell_x;
    logic [9:0] cell_y;
    logic [9:0] glyph_x;
    logic [9:0] glyph_y;
    logic [1:0] row;
    logic [1:0] col;
    logic       in_rows;
    logic       in_grid;
    logic       caps;
    logic       glyph_on;
    digit_t     value;
    digit_t     shown;

    assign lx = pixel.x - 10'(`MAT_X0);
    assign ly = pixel.y - 10'(`MAT_Y0);
    assign gx = lx - 10'(BW);
    assign gy = ly - 10'(GY);
    assign in_rows = (ly >= GY) && (ly < GY + GRID);
    assign in_grid = in_rows && (lx >= BW) && (lx < BW + GRID);
    assign row = 2'(gy / `MAT_CELL);
    assign col = 2'(gx / `MAT_CELL);
    assign cell_x = gx - 10'(col * `MAT_CELL);
    assign cell_y = gy - 10'(row * `MAT_CELL);

    assign value = mat[row][col];
    assign shown = (cell_x >= ONES_X) ? ((value >= 4'd10) ? value - 4'd10 : value)
                                      : ((value >= 4'd10) ? 4'd1 : 4'd0);
    assign glyph_x = (cell_x >= ONES_X) ? cell_x - 10'(ONES_X) : cell_x - 10'(`MAT_DIGIT_X);
    assign glyph_y = cell_y - 10'(`MAT_DIGIT_Y);

    digit_glyph #(.SCALE(`MAT_DIGIT_SCALE)) u_glyph (
        .digit (shown),
        .x     (glyph_x),
        .y     (glyph_y),
        .pixel (glyph_on)
    );

    // brackets span the grid rows on both sides
    assign caps = (ly < GY + `BRACKET_CAP) || (ly >= GY + GRID - `BRACKET_CAP);
    assign flags.bracket = in_rows
        && (((lx < BW) && (caps || (lx < `BRACKET_SPINE)))
        || ((lx >= BW + GRID) && (lx < 2 * BW + GRID)
        && (caps || (lx >= 2 * BW + GRID - `BRACKET_SPINE))));
    assign flags.cell_border = in_grid
        && ((cell_x < 1) || (cell_x >= `MAT_CELL - 1) || (cell_y < 1) || (cell_y >= `MAT_CELL - 1));
    assign flags.digit = in_grid && glyph_on;

    assign flags.cursor_fill = in_grid && edit.edit_mode && !edit.vec_target
        && (row == edit.row) && (col == edit.col);
    assign flags.cursor_border = flags.cursor_fill
        && ((cell_x < `CURSOR_BAND) || (cell_x >= `MAT_CELL - `CURSOR_BAND)
        || (cell_y < `CURSOR_BAND) || (cell_y >= `MAT_CELL - `CURSOR_BAND));

    a_digit_clear_of_border: assert final (!(flags.cell_border && flags.digit))
        else $error("matrix digit drawn on a cell border");

endmodule

//--- src/pixel_compositor.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module pixel_compositor
    import display_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         bright,
    input  vec_flags_t   vflags,
    input  mat_flags_t   mflags,
    input  chart_flags_t cflags,
    input  logic         locked,
    input  logic         blink,
    output rgb_t         rgb
);

    logic fill;
    logic border;

    assign fill = vflags.cursor_fill || mflags.cursor_fill;
    assign border = vflags.cursor_border || mflags.cursor_border;

    // first match wins
    always_ff @(posedge clk)
    begin
        if (rst)
            rgb <= `BLACK;
        else if (!bright)
            rgb <= `BLACK;
        else if (fill && locked)
            rgb <= `GREEN;
        else if (fill && blink)
            rgb <= `YELLOW;
        else if (border)
            rgb <= locked ? `GREEN : `ORANGE;
        else if (cflags.old_bar)
            rgb <= `CYAN;
        else if (cflags.new_bar)
            rgb <= `GREEN;
        else if (cflags.frame)
            rgb <= `GRAY;
        else if (vflags.bracket || mflags.bracket)
            rgb <= `WHITE;
        else if (mflags.cell_border)
            rgb <= `GRAY;
        else if (vflags.digit)
            rgb <= `CYAN;
        else if (mflags.digit)
            rgb <= `WHITE;
        else
            rgb <= `BLACK;
    end

    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        !bright |=> rgb == `BLACK)
        else $error("colour driven during blanking");

endmodule

//--- src/raster_timebase.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module raster_timebase
    import display_pkg::*;
#(
    parameter int BLINK_BIT = 24
)
(
    input  logic        clk,
    input  logic        rst,
    input  raster_t     raster,
    input  frame_data_t data,
    input  edit_t       edit,
    output pixel_t      pixel,
    output frame_data_t data_q,
    output edit_t       edit_q,
    output logic        blink
);

    logic [BLINK_BIT:0] blink_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pixel <= '0;
            blink_cnt <= '0;
            blink <= 1'b0;
        end
        else
        begin
            pixel.bright <= raster.bright;
            pixel.x <= raster.hcount - 10'(`H_BACK);
            pixel.y <= raster.vcount - 10'(`V_BACK);
            blink_cnt <= blink_cnt + 1'b1;
            // blink travels with the pixel sampled at this edge
            blink <= blink_cnt[BLINK_BIT];
        end
    end

    // frame data and edit state follow the pixel so all panels see one frame
    always_ff @(posedge clk)
    begin
        data_q <= data;
        edit_q <= edit;
    end

    a_blink_step: assert property (@(posedge clk) disable iff (rst)
        !rst |=> blink_cnt == $past(blink_cnt) + 1'b1)
        else $error("blink counter did not advance by one");

endmodule

//--- src/vector_panel.sv
`timescale 1ns/1ns
`include "display_settings.svh"

module vector_panel
    import display_pkg::*;
(
    input  pixel_t     pixel,
    input  vec4_t      vec,
    input  edit_t      edit,
    output vec_flags_t flags
);

    localparam int WIDTH = `VEC_X1 - `VEC_X0;
    localparam int HEIGHT = 4 * `VEC_CELL_H;
    localparam int DIGIT_W = `FONT_W << `VEC_DIGIT_SCALE;
    localparam int ONES_X = `VEC_DIGIT_X + DIGIT_W + `VEC_DIGIT_GAP;

    logic [9:0] lx;
    logic [9:0] ly;
    logic [9:0] cell_y;
    logic [9:0] glyph_x;
    logic [9:0] glyph_y;
    logic [1:0] idx;
    logic       in_panel;
    logic       caps;
    logic       glyph_on;
    digit_t     value;
    digit_t     shown;

    assign lx = pixel.x - 10'(`VEC_X0);
    assign ly = pixel.y - 10'(`VEC_Y0);
    assign in_panel = (lx < WIDTH) && (ly < HEIGHT);
    assign idx = 2'(ly / `VEC_CELL_H);
    assign cell_y = ly - 10'(idx * `VEC_CELL_H);

    // values stop at 15, so the tens digit is only ever 0 or 1
    assign value = vec[idx];
    assign shown = (lx >= ONES_X) ? ((value >= 4'd10) ? value - 4'd10 : value)
                                  : ((value >= 4'd10) ? 4'd1 : 4'd0);
    assign glyph_x = (lx >= ONES_X) ? lx - 10'(ONES_X) : lx - 10'(`VEC_DIGIT_X);
    assign glyph_y = cell_y - 10'(`VEC_DIGIT_Y);

    digit_glyph #(.SCALE(`VEC_DIGIT_SCALE)) u_glyph (
        .digit (shown),
        .x     (glyph_x),
        .y     (glyph_y),
        .pixel (glyph_on)
    );

    assign caps = (ly < `BRACKET_CAP) || (ly >= HEIGHT - `BRACKET_CAP);
    assign flags.bracket = in_panel
        && (((lx < `VEC_BRACKET_W) && (caps || (lx < `BRACKET_SPINE)))
        || ((lx >= WIDTH - `VEC_BRACKET_W) && (caps || (lx >= WIDTH - `BRACKET_SPINE))));
    assign flags.digit = in_panel && glyph_on;

    assign flags.cursor_fill = in_panel && edit.edit_mode && edit.vec_target
        && (idx == edit.row);
    assign flags.cursor_border = flags.cursor_fill
        && ((cell_y < `CURSOR_BAND) || (cell_y >= `VEC_CELL_H - `CURSOR_BAND)
        || (lx < `VEC_CURSOR_INSET) || (lx >= WIDTH - `VEC_CURSOR_INSET));

    a_digit_clear_of_band: assert final (!(flags.cursor_border && flags.digit))
        else $error("vector digit drawn inside the cursor band");

endmodule
